//--- source/mbox_pkg.sv
`default_nettype none

package mbox_pkg;

    localparam int MBOX_DEPTH = 64;
    localparam int MBOX_AW = 6;

    // fixed mailbox layout
    localparam logic [MBOX_AW-1:0] DOORBELL_ADDR = 6'd0;
    localparam logic [MBOX_AW-1:0] HEADER_ADDR = 6'd1;
    localparam logic [MBOX_AW-1:0] MSG_BASE = 6'd2;

    localparam logic [7:0] DB_START = 8'h01;
    localparam logic [7:0] DB_DONE = 8'h02;

    localparam int PAYLOAD_MAX = 16;

    typedef enum logic [7:0] {
        OP_ECHO    = 8'h00,
        OP_INVERT  = 8'h01,
        OP_REVERSE = 8'h02,
        OP_SUM     = 8'h03
    } op_t;

    typedef enum logic [2:0] {
        POLL,
        HEADER,
        SEND,
        COLLECT,
        DONE,
        REARM
    } seq_state_t;

    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } stream_byte_t;

    typedef struct packed {
        logic               write;
        logic [MBOX_AW-1:0] addr;
        logic [31:0]        wdata;
    } host_cmd_t;

    typedef struct packed {
        logic [3:0]         we;   // one enable per byte lane
        logic [MBOX_AW-1:0] addr;
        logic [31:0]        wdata;
    } ram_port_t;

endpackage

`default_nettype wire

//--- source/mailbox_ram.sv
`timescale 1ns/100ps
`default_nettype none

module mailbox_ram import mbox_pkg::*; (
    input  logic        clk,
    input  ram_port_t   port_a,
    output logic [31:0] rdata_a,
    input  ram_port_t   port_b,
    output logic [31:0] rdata_b
);

    logic [31:0] mem [MBOX_DEPTH];

    // both ports are read-first, a read in the same cycle as a write sees the old word
    always_ff @(posedge clk) begin
        rdata_a <= mem[port_a.addr];
        rdata_b <= mem[port_b.addr];
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (port_a.we[i]) begin
                mem[port_a.addr][8*i +: 8] <= port_a.wdata[8*i +: 8];
            end
        end
        // port B comes second so it wins a same word collision
        for (int i = 0; i < 4; i++) begin
            if (port_b.we[i]) begin
                mem[port_b.addr][8*i +: 8] <= port_b.wdata[8*i +: 8];
            end
        end
    end

endmodule

`default_nettype wire

//--- source/mbox_host_port.sv
`timescale 1ns/100ps
`default_nettype none

module mbox_host_port import mbox_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        host_req,
    input  host_cmd_t   host_cmd,
    output logic        host_ack,
    output logic [31:0] host_rdata,
    output ram_port_t   ram_a,
    input  logic [31:0] rdata_a
);

    typedef enum logic [1:0] {
        HP_IDLE,
        HP_ACCESS,
        HP_WAIT,
        HP_ACK
    } host_state_t;

    host_state_t state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= HP_IDLE;
        end else begin
            case (state)
                HP_IDLE:   if (host_req) state <= HP_ACCESS;
                HP_ACCESS: state <= HP_WAIT;
                HP_WAIT:   state <= HP_ACK;
                HP_ACK:    if (!host_req) state <= HP_IDLE;   // hold ack until req drops
                default:   state <= HP_IDLE;
            endcase
        end
    end

    // read word is captured once and held for the whole ack phase
    always_ff @(posedge clk) begin
        if (state == HP_WAIT) begin
            host_rdata <= rdata_a;
        end
    end

    always_comb begin
        ram_a.addr = host_cmd.addr;
        ram_a.wdata = host_cmd.wdata;
        ram_a.we = 4'h0;
        if (state == HP_ACCESS && host_cmd.write) begin
            ram_a.we = 4'hf;   // exactly one RAM cycle per request
        end
    end

    assign host_ack = (state == HP_ACK);

endmodule

`default_nettype wire

//--- source/mbox_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module mbox_sequencer import mbox_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    output ram_port_t    ram_b,
    input  logic [31:0]  rdata_b,
    output stream_byte_t tx,
    output logic         tx_valid,
    input  logic         tx_ready,
    input  stream_byte_t rx,
    input  logic         rx_valid,
    output logic         rx_ready
);

    seq_state_t state;
    logic phase;                 // poll slot in POLL, second header cycle in HEADER
    logic [15:0] msg_left;
    logic [15:0] cap_left;
    logic [15:0] ret_count;
    logic [MBOX_AW-1:0] ptr;     // word being read in SEND, next return word in COLLECT
    logic tx_fire;
    logic rx_fire;

    assign tx_fire = tx_valid && tx_ready;
    assign rx_fire = rx_valid && rx_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= POLL;
            phase <= 1'b0;
            msg_left <= '0;
            cap_left <= '0;
            ret_count <= '0;
            ptr <= DOORBELL_ADDR;
        end else begin
            case (state)
                POLL: begin
                    phase <= ~phase;
                    // the doorbell read issued on the even cycle lands on the odd one
                    if (phase && rdata_b[7:0] == DB_START) begin
                        state <= HEADER;
                        phase <= 1'b0;
                    end
                end
                HEADER: begin
                    phase <= ~phase;
                    if (phase) begin
                        msg_left <= rdata_b[15:0];
                        cap_left <= rdata_b[31:16];
                        ret_count <= '0;
                        ptr <= MSG_BASE;
                        phase <= 1'b0;
                        state <= (rdata_b[15:0] == 16'd0) ? DONE : SEND;
                    end
                end
                SEND: begin
                    if (tx_fire) begin
                        ptr <= ptr + 1'b1;
                        msg_left <= msg_left - 1'b1;
                        if (tx.last) state <= COLLECT;   // ptr now sits on the first return word
                    end
                end
                COLLECT: begin
                    if (rx_fire) begin
                        if (cap_left != 16'd0) begin
                            ptr <= ptr + 1'b1;
                            cap_left <= cap_left - 1'b1;
                            ret_count <= ret_count + 1'b1;
                        end
                        if (rx.last) state <= DONE;
                    end
                end
                DONE: state <= REARM;
                REARM: begin
                    // gives the done write time to settle before polling again
                    state <= POLL;
                    phase <= 1'b0;
                end
                default: state <= POLL;
            endcase
        end
    end

    always_comb begin
        ram_b.we = 4'h0;
        ram_b.addr = ptr;
        ram_b.wdata = 32'h0;
        tx.data = 8'h00;
        tx.last = 1'b0;
        tx_valid = 1'b0;
        rx_ready = 1'b0;
        case (state)
            POLL, REARM: ram_b.addr = DOORBELL_ADDR;
            HEADER: ram_b.addr = phase ? MSG_BASE : HEADER_ADDR;
            SEND: begin
                tx.data = rdata_b[7:0];
                tx.last = (msg_left == 16'd1);
                tx_valid = 1'b1;
                if (tx_ready) begin
                    ram_b.addr = ptr + 1'b1;   // read ahead only once the byte is taken
                end
            end
            COLLECT: begin
                rx_ready = 1'b1;
                // bytes past the capacity are accepted and thrown away
                if (rx_valid && cap_left != 16'd0) begin
                    ram_b.we = 4'hf;
                    ram_b.wdata = {24'h0, rx.data};
                end
            end
            DONE: begin
                ram_b.addr = DOORBELL_ADDR;
                ram_b.we = 4'hf;
                ram_b.wdata = {ret_count, 8'h00, DB_DONE};
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- source/byte_engine.sv
`timescale 1ns/100ps
`default_nettype none

module byte_engine import mbox_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  stream_byte_t in_byte,
    input  logic         in_valid,
    output logic         in_ready,
    output stream_byte_t out_byte,
    output logic         out_valid,
    input  logic         out_ready
);

    typedef enum logic [1:0] {
        E_OPCODE,
        E_PAYLOAD,
        E_EMIT
    } eng_state_t;

    eng_state_t state;
    op_t op;
    logic [7:0] payload [PAYLOAD_MAX];
    logic [$clog2(PAYLOAD_MAX):0] stored;      // 0 to PAYLOAD_MAX bytes kept
    logic [$clog2(PAYLOAD_MAX)-1:0] idx;
    logic [$clog2(PAYLOAD_MAX):0] rev_idx;
    logic [7:0] sum;
    logic in_fire;
    logic out_fire;

    assign in_ready = (state != E_EMIT);
    assign out_valid = (state == E_EMIT);
    assign in_fire = in_valid && in_ready;
    assign out_fire = out_valid && out_ready;
    assign rev_idx = stored - 1'b1 - {1'b0, idx};

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= E_OPCODE;
            stored <= '0;
            idx <= '0;
        end else begin
            case (state)
                E_OPCODE: begin
                    if (in_fire) begin
                        stored <= '0;
                        idx <= '0;
                        state <= in_byte.last ? E_EMIT : E_PAYLOAD;
                    end
                end
                E_PAYLOAD: begin
                    if (in_fire) begin
                        if (stored < PAYLOAD_MAX) stored <= stored + 1'b1;   // extra bytes are ignored
                        if (in_byte.last) state <= E_EMIT;
                    end
                end
                E_EMIT: begin
                    if (out_fire) begin
                        idx <= idx + 1'b1;
                        if (out_byte.last) begin
                            state <= E_OPCODE;
                            idx <= '0;
                        end
                    end
                end
                default: state <= E_OPCODE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire && state == E_OPCODE) begin
            op <= op_t'(in_byte.data);   // unknown codes fall back to echo below
            sum <= 8'h00;
        end
        if (in_fire && state == E_PAYLOAD && stored < PAYLOAD_MAX) begin
            payload[stored[$clog2(PAYLOAD_MAX)-1:0]] <= in_byte.data;
            sum <= sum + in_byte.data;
        end
    end

    always_comb begin
        // an opcode-only frame still answers with a single zero byte
        out_byte.last = (stored == '0) || ({1'b0, idx} == stored - 1'b1);
        if (stored == '0) begin
            out_byte.data = 8'h00;
        end else begin
            case (op)
                OP_INVERT:  out_byte.data = ~payload[idx];
                OP_REVERSE: out_byte.data = payload[rev_idx[$clog2(PAYLOAD_MAX)-1:0]];
                OP_SUM:     out_byte.data = sum;
                default:    out_byte.data = payload[idx];
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/mbox_top.sv
`timescale 1ns/100ps
`default_nettype none

module mbox_top import mbox_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        host_req,
    input  host_cmd_t   host_cmd,
    output logic        host_ack,
    output logic [31:0] host_rdata
);

    ram_port_t ram_a;
    ram_port_t ram_b;
    logic [31:0] rdata_a;
    logic [31:0] rdata_b;
    stream_byte_t tx;
    stream_byte_t rx;
    logic tx_valid;
    logic tx_ready;
    logic rx_valid;
    logic rx_ready;

    mbox_host_port u_host (
        .clk        (clk),
        .reset      (reset),
        .host_req   (host_req),
        .host_cmd   (host_cmd),
        .host_ack   (host_ack),
        .host_rdata (host_rdata),
        .ram_a      (ram_a),
        .rdata_a    (rdata_a)
    );

    mailbox_ram u_ram (
        .clk     (clk),
        .port_a  (ram_a),
        .rdata_a (rdata_a),
        .port_b  (ram_b),
        .rdata_b (rdata_b)
    );

    // port B belongs to the sequencer alone
    mbox_sequencer u_seq (
        .clk      (clk),
        .reset    (reset),
        .ram_b    (ram_b),
        .rdata_b  (rdata_b),
        .tx       (tx),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .rx       (rx),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready)
    );

    byte_engine u_engine (
        .clk       (clk),
        .reset     (reset),
        .in_byte   (tx),
        .in_valid  (tx_valid),
        .in_ready  (tx_ready),
        .out_byte  (rx),
        .out_valid (rx_valid),
        .out_ready (rx_ready)
    );

endmodule

`default_nettype wire

//--- tb/mbox_chk.sv
`timescale 1ns/100ps
`default_nettype none

module mbox_chk import mbox_pkg::*; (
    input logic         clk,
    input logic         reset,
    input logic         host_req,
    input logic         host_ack,
    input stream_byte_t tx,
    input logic         tx_valid,
    input logic         tx_ready,
    input stream_byte_t rx,
    input logic         rx_valid,
    input logic         rx_ready,
    input ram_port_t    ram_a,
    input seq_state_t   seq_state
);

    ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(host_ack) |-> host_req)
        else $error("host_ack rose while host_req was low");

    tx_hold: assert property (@(posedge clk) disable iff (reset)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx))
        else $error("tx changed or dropped before the engine took it");

    rx_hold: assert property (@(posedge clk) disable iff (reset)
        rx_valid && !rx_ready |=> rx_valid && $stable(rx))
        else $error("rx changed or dropped before the sequencer took it");

    // the doorbell belongs to the host only while the sequencer polls
    doorbell_write_in_poll: assert property (@(posedge clk) disable iff (reset)
        ram_a.we != 4'h0 && ram_a.addr == DOORBELL_ADDR |-> seq_state == POLL)
        else $error("host wrote the doorbell while the sequencer was not in POLL");

endmodule

bind mbox_top mbox_chk u_chk (
    .clk       (clk),
    .reset     (reset),
    .host_req  (host_req),
    .host_ack  (host_ack),
    .tx        (tx),
    .tx_valid  (tx_valid),
    .tx_ready  (tx_ready),
    .rx        (rx),
    .rx_valid  (rx_valid),
    .rx_ready  (rx_ready),
    .ram_a     (ram_a),
    .seq_state (u_seq.state)
);

`default_nettype wire

//--- tb/mbox_checker.sv
`timescale 1ns/100ps
`default_nettype none

module mbox_checker import mbox_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        host_ack,
    input  host_cmd_t   host_cmd,
    input  logic [31:0] host_rdata,
    input  logic        push,
    input  logic        push_check,
    input  logic [31:0] push_word,
    output int          mismatch_count,
    output int          check_count,
    output int          other_count,
    output int          pending
);

    logic [32:0] exp_q [$];   // check flag on top of the expected word
    logic ack_q;

    assign pending = exp_q.size();

    always @(posedge clk) begin : compare
        logic [32:0] entry;
        if (reset) begin
            ack_q <= 1'b0;
            mismatch_count = 0;
            check_count = 0;
            other_count = 0;
            exp_q.delete();
        end else begin
            ack_q <= host_ack;
            if (push) exp_q.push_back({push_check, push_word});
            // one entry per read, taken on the rising ack only
            if (host_ack && !ack_q && !host_cmd.write) begin
                if (exp_q.size() == 0) begin
                    $display("read of word %0d acknowledged at %0t ns with nothing expected",
                             host_cmd.addr, $time);
                    other_count++;
                end else begin
                    entry = exp_q.pop_front();
                    if (entry[32]) begin
                        check_count++;
                        if (host_rdata !== entry[31:0]) begin
                            $display("Mismatch at %0t ns: host_rdata word %0d expected %08h actual %08h",
                                     $time, host_cmd.addr, entry[31:0], host_rdata);
                            mismatch_count++;
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/mbox_tb.sv
`timescale 1ns/100ps
`default_nettype none

module mbox_tb import mbox_pkg::*; ();

    logic clk;
    logic reset;
    logic host_req;
    host_cmd_t host_cmd;
    logic host_ack;
    logic [31:0] host_rdata;
    logic push;
    logic push_check;
    logic [31:0] push_word;
    int mismatch_count;
    int check_count;
    int other_count;
    int pending;
    int other_errors;
    int n_entries;
    logic loaded;
    logic [15:0] cap_q [$];
    logic [15:0] cnt_q [$];
    logic [15:0] nret_q [$];
    logic [7:0] msg_q [$];
    logic [7:0] ret_q [$];

    mbox_top UUT (
        .clk        (clk),
        .reset      (reset),
        .host_req   (host_req),
        .host_cmd   (host_cmd),
        .host_ack   (host_ack),
        .host_rdata (host_rdata)
    );

    mbox_checker u_checker (
        .clk            (clk),
        .reset          (reset),
        .host_ack       (host_ack),
        .host_cmd       (host_cmd),
        .host_rdata     (host_rdata),
        .push           (push),
        .push_check     (push_check),
        .push_word      (push_word),
        .mismatch_count (mismatch_count),
        .check_count    (check_count),
        .other_count    (other_count),
        .pending        (pending)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // preload value, distinct for every word address
    function automatic logic [31:0] fill_word(input logic [MBOX_AW-1:0] addr);
        return {2'b10, addr, 2'b01, ~addr, 2'b11, addr, 8'h5a};
    endfunction

    function automatic logic [31:0] msg_word(input logic [MBOX_AW-1:0] addr, input logic [7:0] b);
        logic [31:0] w;
        w = fill_word(addr);
        return {w[31:8], b};   // sequencer only looks at the low byte
    endfunction

    // one full four-phase access, called right after a rising edge
    task automatic host_access(input logic is_write, input logic [MBOX_AW-1:0] addr,
                               input logic [31:0] wdata, input logic check,
                               input logic [31:0] expect_word, output logic [31:0] rdata);
        host_cmd <= '{is_write, addr, wdata};
        host_req <= 1'b1;
        push <= !is_write;
        push_check <= check;
        push_word <= expect_word;
        @(posedge clk);
        push <= 1'b0;
        while (!host_ack) @(posedge clk);
        rdata = host_rdata;
        host_req <= 1'b0;
        while (host_ack) @(posedge clk);
    endtask

    task automatic run_message(input logic [15:0] cap, input logic [15:0] cnt,
                               input logic [15:0] nret);
        logic [MBOX_AW-1:0] ret_base;
        logic [MBOX_AW-1:0] addr;
        logic [31:0] rd;
        logic [7:0] msg [$];
        ret_base = MSG_BASE + cnt[MBOX_AW-1:0];
        host_access(1'b1, HEADER_ADDR, {cap, cnt}, 1'b0, '0, rd);
        for (int k = 0; k < cnt; k++) begin
            msg.push_back(msg_q.pop_front());
            addr = MSG_BASE + k[MBOX_AW-1:0];
            host_access(1'b1, addr, msg_word(addr, msg[k]), 1'b0, '0, rd);
        end
        for (int j = 0; j <= nret; j++) begin
            addr = ret_base + j[MBOX_AW-1:0];
            host_access(1'b1, addr, fill_word(addr), 1'b0, '0, rd);
        end
        host_access(1'b1, DOORBELL_ADDR, {24'h0, DB_START}, 1'b0, '0, rd);
        rd = '0;
        while (rd[7:0] != DB_DONE) host_access(1'b0, DOORBELL_ADDR, '0, 1'b0, '0, rd);
        host_access(1'b0, DOORBELL_ADDR, '0, 1'b1, {nret, 8'h00, DB_DONE}, rd);
        for (int j = 0; j < nret; j++) begin
            addr = ret_base + j[MBOX_AW-1:0];
            host_access(1'b0, addr, '0, 1'b1, {24'h0, ret_q.pop_front()}, rd);
        end
        addr = ret_base + nret[MBOX_AW-1:0];   // first word past the returns keeps its preload
        host_access(1'b0, addr, '0, 1'b1, fill_word(addr), rd);
        for (int k = 0; k < cnt; k++) begin
            addr = MSG_BASE + k[MBOX_AW-1:0];
            host_access(1'b0, addr, '0, 1'b1, msg_word(addr, msg[k]), rd);
        end
    endtask

    initial begin
        int fd;
        logic [31:0] v;
        logic [15:0] n;
        logic [8*80-1:0] line;
        logic [31:0] rd;
        reset = 1'b1;
        host_req = 1'b0;
        host_cmd = '0;
        push = 1'b0;
        push_check = 1'b0;
        push_word = '0;
        other_errors = 0;
        n_entries = 0;
        loaded = 1'b0;
        fd = $fopen("tb/mbox_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file tb/mbox_stim.txt");
            other_errors++;
        end else begin
            void'($fgets(line, fd));
            void'($fgets(line, fd));
            while ($fscanf(fd, "%h", v) == 1) begin
                cap_q.push_back(v[15:0]);
                void'($fscanf(fd, "%h", v));
                n = v[15:0];
                cnt_q.push_back(n);
                repeat (n) begin
                    void'($fscanf(fd, "%h", v));
                    msg_q.push_back(v[7:0]);
                end
                void'($fscanf(fd, "%h", v));
                n = v[15:0];
                nret_q.push_back(n);
                repeat (n) begin
                    void'($fscanf(fd, "%h", v));
                    ret_q.push_back(v[7:0]);
                end
                n_entries++;
            end
            $fclose(fd);
        end
        loaded = 1'b1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        host_access(1'b1, DOORBELL_ADDR, '0, 1'b0, '0, rd);
        while (cap_q.size() > 0) begin
            run_message(cap_q.pop_front(), cnt_q.pop_front(), nret_q.pop_front());
        end
        repeat (2) @(posedge clk);
        if (pending != 0) begin
            $display("%0d expected words were queued but never read back", pending);
            other_errors++;
        end
        if (check_count == 0) begin
            $display("no returned word was compared");
            other_errors++;
        end
        $display("errors: %0d mismatches, %0d other, %0d words checked",
                 mismatch_count, other_errors + other_count, check_count);
        if (mismatch_count == 0 && other_errors + other_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        wait (loaded && n_entries > 0);
        #(n_entries * 2000);
        $display("timeout after %0d ns, the doorbell never reported done", n_entries * 2000);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
source/mbox_pkg.sv
source/mailbox_ram.sv
source/mbox_host_port.sv
source/mbox_sequencer.sv
source/byte_engine.sv
source/mbox_top.sv
tb/mbox_chk.sv
tb/mbox_checker.sv
tb/mbox_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module mbox_tb -f vlog.f -o mbox_sim

out=$(./obj_dir/mbox_sim || true)
echo "$out"
echo "$out" | grep -q "Testbench passed"

//--- tb/mbox_stim.txt
# hex columns: capacity, count, count message bytes (opcode first),
# then done count and that many expected return bytes
8 5 00 11 22 33 44 4 11 22 33 44
8 4 01 0f a5 3c 3 f0 5a c3
8 6 02 01 02 03 04 05 5 05 04 03 02 01
8 4 03 10 20 f5 3 25 25 25
3 7 02 a1 b2 c3 d4 e5 f6 3 f6 e5 d4
2 11 01 00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 2 ff fe
10 9 03 01 02 03 04 05 06 07 08 8 24 24 24 24 24 24 24 24
4 0 0
4 1 01 1 00
4 3 07 9c 9d 2 9c 9d
